/* common/pe_pkg.sv */
package pe_pkg;

    // one word for values, one for coordinates
    localparam int WORD_W  = 8;
    localparam int COORD_W = 8;

    // pixels per feature beat, weight slots and window groups
    localparam int LANES = 4;

    // beat opcode
    typedef enum logic {
        OP_WEIGHT  = 1'b0,
        OP_FEATURE = 1'b1
    } pe_op_e;

    // loader FSM
    typedef enum logic [1:0] {
        EMPTY     = 2'b00,
        LOADING   = 2'b01,
        FILLING   = 2'b10,
        STREAMING = 2'b11
    } load_state_e;

    // one weight or one pixel with its position
    typedef struct packed {
        logic signed [WORD_W-1:0]  value;
        logic signed [COORD_W-1:0] col;
        logic signed [COORD_W-1:0] row;
    } point_t;

    // input beat whose op selects the meaningful part
    typedef struct packed {
        pe_op_e                op;
        point_t                weight;
        point_t [LANES-1:0]    feature;
    } beat_t;

    typedef point_t [LANES-1:0] bank_t;

    // indexed window[group][pixel] with group 0 newest
    typedef point_t [LANES-1:0][LANES-1:0] window_t;

    typedef struct packed {
        logic signed [WORD_W-1:0]  value;
        logic signed [COORD_W-1:0] col_diff;
        logic signed [COORD_W-1:0] row_diff;
    } result_t;

    // lane (k, j) at index k*LANES+j
    typedef result_t [LANES*LANES-1:0] grid_out_t;

endpackage

/* pe_array/pe_lane_cell.sv */
`timescale 1ns/10ps

module pe_lane_cell #(
    parameter int FRAC_W = 4
) (
    input  pe_pkg::point_t  weight,
    input  pe_pkg::point_t  pixel,
    output pe_pkg::result_t result
);

    import pe_pkg::*;

    // full-width signed product
    logic signed [2*WORD_W-1:0]  product;
    logic signed [COORD_W-1:0]   col_diff;
    logic signed [COORD_W-1:0]   row_diff;

    assign product = $signed(weight.value) * $signed(pixel.value);

    // wraps mod 2^COORD_W
    assign col_diff = pixel.col - weight.col;
    assign row_diff = pixel.row - weight.row;

    always_comb begin
        // drop FRAC_W fraction bits, keep one word above them
        result.value    = product[FRAC_W +: WORD_W];
        result.col_diff = col_diff;
        result.row_diff = row_diff;
    end

endmodule

/* pe_array/pe_mac_grid.sv */
`timescale 1ns/10ps

module pe_mac_grid #(
    parameter int FRAC_W = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              window_valid,
    input  pe_pkg::bank_t     bank,
    input  pe_pkg::window_t   window,
    output logic              out_valid,
    output pe_pkg::grid_out_t out_result
);

    import pe_pkg::*;

    // combinational lane results
    grid_out_t lane_res;

    // weight slot k against every pixel of group k
    for (genvar k = 0; k < LANES; k++) begin : g_slot
        for (genvar j = 0; j < LANES; j++) begin : g_pixel
            pe_lane_cell #(
                .FRAC_W (FRAC_W)
            ) u_cell (
                .weight (bank[k]),
                .pixel  (window[k][j]),
                .result (lane_res[k*LANES+j])
            );
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= window_valid;
        end
    end

    // result holds between windows
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_result <= '0;
        end else if (window_valid) begin
            out_result <= lane_res;
        end
    end

endmodule

/* pe_array/pe_loader.sv */
`timescale 1ns/10ps

module pe_loader (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  pe_pkg::beat_t   in_beat,
    output logic            window_valid,
    output pe_pkg::bank_t   bank,
    output pe_pkg::window_t window
);

    import pe_pkg::*;

    localparam int PTR_W = $clog2(LANES);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(LANES - 1);

    // sampled beat
    logic        beat_vld_q;
    beat_t       beat_q;

    load_state_e state_q;
    load_state_e state_d;
    logic [PTR_W-1:0] slot_ptr;
    logic [PTR_W-1:0] fill_cnt;
    logic [PTR_W-1:0] fill_cnt_d;
    logic        take_weight;
    logic        take_feature;
    logic        win_vld_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_vld_q <= 1'b0;
        end else begin
            beat_vld_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            beat_q <= in_beat;
        end
    end

    assign take_weight = beat_vld_q && (beat_q.op == OP_WEIGHT);

    // features only count once the bank holds a full set
    assign take_feature = beat_vld_q && (beat_q.op == OP_FEATURE) &&
                          ((state_q == FILLING) || (state_q == STREAMING));

    always_comb begin
        state_d    = state_q;
        fill_cnt_d = fill_cnt;
        win_vld_d  = 1'b0;
        if (take_weight) begin
            fill_cnt_d = '0;
            if (slot_ptr == LAST) begin
                state_d = FILLING;
            end else begin
                state_d = LOADING;
            end
        end else if (take_feature) begin
            if (state_q == FILLING) begin
                fill_cnt_d = fill_cnt + 1'b1;
                // fourth group completes the window
                if (fill_cnt == LAST) begin
                    state_d   = STREAMING;
                    win_vld_d = 1'b1;
                end
            end else begin
                win_vld_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= EMPTY;
            slot_ptr     <= '0;
            fill_cnt     <= '0;
            window_valid <= 1'b0;
        end else begin
            state_q      <= state_d;
            fill_cnt     <= fill_cnt_d;
            window_valid <= win_vld_d;
            // wraps 3 -> 0
            if (take_weight) begin
                slot_ptr <= slot_ptr + 1'b1;
            end
        end
    end

    // weight bank
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank <= '0;
        end else if (take_weight) begin
            bank[slot_ptr] <= beat_q.weight;
        end
    end

    // oldest group drops out of the top as the window shifts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window <= '0;
        end else if (take_feature) begin
            for (int g = LANES - 1; g > 0; g--) begin
                window[g] <= window[g-1];
            end
            window[0] <= beat_q.feature;
        end
    end

endmodule

/* src/pe_top.sv */
`timescale 1ns/10ps

module pe_top #(
    parameter int FRAC_W = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  pe_pkg::beat_t     in_beat,
    output logic              out_valid,
    output pe_pkg::grid_out_t out_result
);

    import pe_pkg::*;

    // loader to grid
    logic    window_valid;
    bank_t   bank;
    window_t window;

    // input register, FSM, weight bank and sliding window
    pe_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_beat      (in_beat),
        .window_valid (window_valid),
        .bank         (bank),
        .window       (window)
    );

    // registered 4x4 multiply and coordinate diffs
    pe_mac_grid #(
        .FRAC_W (FRAC_W)
    ) u_grid (
        .clk          (clk),
        .rst          (rst),
        .window_valid (window_valid),
        .bank         (bank),
        .window       (window),
        .out_valid    (out_valid),
        .out_result   (out_result)
    );

endmodule

/* verification/pe_sva.sv */
`timescale 1ns/10ps

module pe_sva (
    input logic              clk,
    input logic              rst,
    input logic              in_valid,
    input logic              out_valid,
    input pe_pkg::grid_out_t out_result
);

    int fail_cnt = 0;

    a_reset_idle: assert property (@(posedge clk) rst |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_cnt++;
        end

    // input register, loader, grid register
    a_latency: assert property (@(posedge clk) disable iff (rst)
                                out_valid |-> $past(in_valid, 3))
        else begin
            $error("out_valid without a sampled beat three cycles before");
            fail_cnt++;
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
                             !out_valid |-> $stable(out_result))
        else begin
            $error("out_result changed while out_valid was low");
            fail_cnt++;
        end

endmodule

/* verification/pe_checker.sv */
`timescale 1ns/10ps

module pe_checker (
    input logic              clk,
    input logic              rst,
    input logic              out_valid,
    input pe_pkg::grid_out_t out_result,
    input logic              finished
);

    import pe_pkg::*;

    int        value_errs = 0;
    int        other_errs = 0;
    int        seen = 0;
    string     name_q[$];
    grid_out_t exp_q[$];

    task automatic add_expected(input string name, input grid_out_t res);
        name_q.push_back(name);
        exp_q.push_back(res);
    endtask

    task automatic compare_result(input string name, input grid_out_t exp_res,
                                  input grid_out_t act);
        for (int i = 0; i < LANES*LANES; i++) begin
            if (act[i] !== exp_res[i]) begin
                $display("Fail %s lane %0d: expected %h %h %h, actual %h %h %h",
                         name, i,
                         exp_res[i].value, exp_res[i].col_diff, exp_res[i].row_diff,
                         act[i].value, act[i].col_diff, act[i].row_diff);
                value_errs++;
            end
        end
    endtask

    // each out_valid cycle consumes the next expected record
    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("a result appeared at %0t with no expected result left", $time);
                    other_errs++;
                end else begin
                    compare_result(name_q.pop_front(), exp_q.pop_front(), out_result);
                end
                seen++;
            end else if (seen == 0 && out_result !== '0) begin
                $display("Fail reset_idle: expected %h, actual %h", grid_out_t'('0), out_result);
                value_errs++;
            end
        end
    end

    always @(posedge finished) begin
        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared, first missing is %s",
                     exp_q.size(), name_q[0]);
            other_errs += exp_q.size();
        end
    end

endmodule

/* verification/tb_pe.sv */
`timescale 1ns/10ps

module tb_pe;

    import pe_pkg::*;

    localparam int    CLK_PERIOD = 10;
    localparam int    RST_CYCLES = 4;
    // input register, loader update, grid register
    localparam int    LATENCY    = 3;
    localparam string VEC_FILE   = "verification/pe_vectors.txt";

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    beat_t     in_beat;
    logic      out_valid;
    grid_out_t out_result;
    logic      finished;

    logic      valid_q[$];
    beat_t     beat_q[$];
    int        gap_q[$];
    int        cycle_limit = 0;
    int        read_errs = 0;
    int        total_errs;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pe_top #(
        .FRAC_W (4)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    pe_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .out_result (out_result),
        .finished   (finished)
    );

    bind pe_top pe_sva u_sva (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    function automatic point_t make_point(logic [7:0] v, logic [7:0] c, logic [7:0] r);
        point_t p;
        p.value = v;
        p.col   = c;
        p.row   = r;
        return p;
    endfunction

    // B records feed the stimulus queues and E records go to the checker
    task automatic read_vectors(input int fd);
        string      tok;
        string      name;
        string      rest;
        int         code;
        int         nread;
        logic [7:0] f[17];
        logic [7:0] r[48];
        beat_t      b;
        grid_out_t  exp_res;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "B") begin
                nread = 0;
                foreach (f[i]) begin
                    code = $fscanf(fd, "%h", f[i]);
                    if (code == 1) begin
                        nread++;
                    end
                end
                if (nread != 17) begin
                    $display("a B record in the vector file has %0d of 17 fields", nread);
                    read_errs++;
                end
                b.op     = pe_op_e'(f[1][0]);
                b.weight = make_point(f[2], f[3], f[4]);
                for (int j = 0; j < LANES; j++) begin
                    b.feature[j] = make_point(f[5+3*j], f[6+3*j], f[7+3*j]);
                end
                valid_q.push_back(f[0][0]);
                beat_q.push_back(b);
            end else if (tok == "E") begin
                code = $fscanf(fd, "%s", name);
                nread = 0;
                foreach (r[i]) begin
                    code = $fscanf(fd, "%h", r[i]);
                    if (code == 1) begin
                        nread++;
                    end
                end
                if (nread != 48) begin
                    $display("the E record %s has %0d of 48 fields", name, nread);
                    read_errs++;
                end
                for (int i = 0; i < LANES*LANES; i++) begin
                    exp_res[i].value    = r[3*i];
                    exp_res[i].col_diff = r[3*i+1];
                    exp_res[i].row_diff = r[3*i+2];
                end
                u_checker.add_expected(name, exp_res);
            end else if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                $display("unexpected token %s in the vector file", tok);
                read_errs++;
            end
        end
    endtask

    task automatic drive_beat(input logic v, input beat_t b);
        @(posedge clk);
        #1;
        in_valid = v;
        in_beat  = b;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    initial begin
        wait (cycle_limit > 0);
        #(cycle_limit * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int fd;
        int gap_sum;
        void'($urandom(10426));
        rst      = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        finished = 1'b0;
        gap_sum  = 0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VEC_FILE);
            read_errs++;
        end else begin
            read_vectors(fd);
            $fclose(fd);
        end
        // 0 to 2 idle cycles ahead of each beat
        foreach (beat_q[i]) begin
            gap_q.push_back($urandom_range(2, 0));
            gap_sum += gap_q[i];
        end
        cycle_limit = beat_q.size() + gap_sum + 20;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (beat_q[i]) begin
            drive_idle(gap_q[i]);
            drive_beat(valid_q[i], beat_q[i]);
        end
        drive_idle(LATENCY + 2);
        finished = 1'b1;
        #1;
        total_errs = read_errs + u_checker.value_errs + u_checker.other_errs +
                     u_dut.u_sva.fail_cnt;
        $display("errors: %0d value, %0d protocol, %0d assertion, %0d vector file",
                 u_checker.value_errs, u_checker.other_errs, u_dut.u_sva.fail_cnt, read_errs);
        if (total_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verification/pe_vectors.txt */
# B valid op  weight val col row  then pixels 0..3 as val col row, hex, op 0 weight 1 feature
# E name  then lanes k*4+j in order as value col_diff row_diff, eight lanes per line
# features before any weight load are dropped
B 1 1  00 00 00  11 00 00  22 01 00  33 02 00  44 03 00
B 1 1  00 00 00  7F 10 10  80 20 20  01 30 30  FF 40 40
# first weight set, slots 0 to 3
B 1 0  10 01 02  00 00 00  00 00 00  00 00 00  00 00 00
B 1 0  20 00 00  00 00 00  00 00 00  00 00 00  00 00 00
B 1 0  F0 03 01  00 00 00  00 00 00  00 00 00  00 00 00
B 1 0  08 05 05  00 00 00  00 00 00  00 00 00  00 00 00
# valid low, data ignored
B 0 1  77 77 77  77 77 77  77 77 77  77 77 77  77 77 77
# window fill, the fourth group gives the first result
B 1 1  00 00 00  11 00 00  22 01 00  33 02 00  44 03 00
B 1 1  00 00 00  50 00 01  60 01 01  70 02 01  7F 03 01
B 1 1  00 00 00  80 00 02  81 01 02  FF 02 02  01 03 02
B 1 1  00 00 00  05 04 03  FB 05 03  40 06 03  C0 07 03
E fill_first  05 03 01  FB 04 01  40 05 01  C0 06 01  00 00 02  02 01 02  FE 02 02  02 03 02
  B0 FD 00  A0 FE 00  90 FF 00  81 00 00  08 FB FB  11 FC FB  19 FD FB  22 FE FB
B 1 1  00 00 00  0A 10 04  14 11 04  1E 12 04  28 13 04
E slide_one  0A 0F 02  14 10 02  1E 11 02  28 12 02  0A 04 03  F6 05 03  80 06 03  80 07 03
  80 FD 01  7F FE 01  01 FF 01  FF 00 01  28 FB FC  30 FC FC  38 FD FC  3F FE FC
B 1 1  00 00 00  F6 08 FF  EC 09 FF  E2 0A FF  D8 0B FF
E slide_two  F6 07 FD  EC 08 FD  E2 09 FD  D8 0A FD  14 10 04  28 11 04  3C 12 04  50 13 04
  FB 01 02  05 02 02  C0 03 02  40 04 02  C0 FB FD  C0 FC FD  FF FD FD  00 FE FD
# reload, the feature beat during LOADING is dropped
B 1 0  7F 00 00  00 00 00  00 00 00  00 00 00  00 00 00
B 1 0  80 10 10  00 00 00  00 00 00  00 00 00  00 00 00
B 1 1  00 00 00  55 55 55  55 55 55  55 55 55  55 55 55
B 1 0  01 FF 01  00 00 00  00 00 00  00 00 00  00 00 00
B 1 0  30 02 FE  00 00 00  00 00 00  00 00 00  00 00 00
B 1 1  00 00 00  01 00 00  02 01 00  03 02 00  04 03 00
B 1 1  00 00 00  10 00 01  20 01 01  F0 02 01  E0 03 01
B 1 1  00 00 00  7F 80 7F  80 81 7F  40 82 7F  C0 83 7F
B 1 1  00 00 00  10 10 05  11 20 05  FF 30 05  20 40 05
E reload_first  7F 10 05  86 20 05  F8 30 05  FE 40 05  08 70 6F  00 71 6F  00 72 6F  00 73 6F
  01 01 00  02 02 00  FF 03 00  FE 04 00  03 FE 02  06 FF 02  09 00 02  0C 01 02
B 1 1  00 00 00  00 FF 80  64 FE 80  9C FD 80  0F FC 80
E reload_slide  00 FF 80  19 FE 80  E6 FD 80  77 FC 80  80 00 F5  78 10 F5  08 20 F5  00 30 F5
  07 81 7E  F8 82 7E  04 83 7E  FC 84 7E  30 FE 03  60 FF 03  D0 00 03  A0 01 03

/* list.f */
common/pe_pkg.sv
pe_array/pe_lane_cell.sv
pe_array/pe_mac_grid.sv
pe_array/pe_loader.sv
src/pe_top.sv
verification/pe_sva.sv
verification/pe_checker.sv
verification/tb_pe.sv
